/* verilog/music_pkg.sv */
/*
 * Music player shared definitions
 * Widths, voice amplitude, control states, note step rule and the song table
 */
package music_pkg;

    localparam int NOTE_W     = 6;
    localparam int SAMPLE_W   = 16;
    localparam int PHASE_W    = 16;
    localparam int SONG_COUNT = 4;
    localparam int SONG_W     = 2;
    localparam int ENTRY_W    = 4;

    // Square wave magnitude, a quarter of it per voice keeps the mix in range
    localparam logic signed [SAMPLE_W-1:0] VOICE_AMP = SAMPLE_W'(16384);

    typedef enum logic {
        MCU_STOPPED,
        MCU_PLAYING
    } mcu_state_t;

    // Phase increment per frame, note 0 is a rest and never moves
    function automatic logic [PHASE_W-1:0] note_step(input logic [NOTE_W-1:0] note);
        return PHASE_W'({note, 6'b0});
    endfunction

    // Entry is {chord, duration, note}
    // A duration of 0 marks the end of the song
    function automatic logic [2*NOTE_W:0] song_entry(input logic [SONG_W-1:0] song,
                                                      input logic [ENTRY_W-1:0] idx);
        case ({song, idx})
            // Song 0: three voice chord, rest, then a chord that forces a wait
            6'h00: return {1'b1, 6'd4, 6'd20};
            6'h01: return {1'b1, 6'd4, 6'd24};
            6'h02: return {1'b0, 6'd2, 6'd30};
            6'h03: return {1'b0, 6'd2, 6'd16};
            6'h04: return {1'b0, 6'd1, 6'd0};
            6'h05: return {1'b1, 6'd3, 6'd40};
            6'h06: return {1'b1, 6'd3, 6'd12};
            6'h07: return {1'b1, 6'd2, 6'd50};
            6'h08: return {1'b0, 6'd1, 6'd33};
            // Song 1
            6'h10: return {1'b0, 6'd2, 6'd10};
            6'h11: return {1'b0, 6'd1, 6'd0};
            6'h12: return {1'b0, 6'd2, 6'd15};
            // Song 2
            6'h20: return {1'b1, 6'd3, 6'd8};
            6'h21: return {1'b0, 6'd3, 6'd45};
            6'h22: return {1'b0, 6'd2, 6'd22};
            // Song 3
            6'h30: return {1'b0, 6'd1, 6'd60};
            6'h31: return {1'b1, 6'd2, 6'd31};
            6'h32: return {1'b0, 6'd2, 6'd5};
            default: return '0;
        endcase
    endfunction

endpackage

/* verilog/mcu.sv */
/*
 * Master control unit
 * Turns play and next button pulses into a play level and a song number
 */
`timescale 1ns/1ps

module mcu (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         play_button,
    input  logic                         next_button,
    input  logic                         song_done,
    output logic                         play,
    output logic                         reset_player,
    output logic [music_pkg::SONG_W-1:0] song
);

    music_pkg::mcu_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= music_pkg::MCU_STOPPED;
            song         <= '0;
            reset_player <= 1'b0;
        end else begin
            reset_player <= 1'b0;
            // Song change wins over play, and always stops playback
            if (next_button || song_done) begin
                state        <= music_pkg::MCU_STOPPED;
                reset_player <= 1'b1;
                if (int'(song) == music_pkg::SONG_COUNT - 1) begin
                    song <= '0;
                end else begin
                    song <= song + 1'b1;
                end
            end else if (play_button) begin
                case (state)
                    music_pkg::MCU_STOPPED: state <= music_pkg::MCU_PLAYING;
                    default:                state <= music_pkg::MCU_STOPPED;
                endcase
            end
        end
    end

    // Decoded straight from the state register
    assign play = (state == music_pkg::MCU_PLAYING);

endmodule

/* verilog/frame_sync.sv */
/*
 * Frame synchronizer
 * One-cycle sample strobe per new_frame rising edge, and a beat every BEAT_COUNT strobes
 */
`timescale 1ns/1ps

module frame_sync #(
    parameter int BEAT_COUNT = 1000
) (
    input  logic clk,
    input  logic reset,
    input  logic new_frame,
    output logic generate_next_sample,
    output logic beat
);

    localparam int CNT_W = (BEAT_COUNT > 1) ? $clog2(BEAT_COUNT) : 1;

    logic             new_frame_d;
    logic             frame_edge;
    logic [CNT_W-1:0] strobe_cnt;

    // Raw codec level, high for a few cycles per frame
    assign frame_edge = new_frame & ~new_frame_d;

    always_ff @(posedge clk) begin
        if (reset) begin
            new_frame_d          <= 1'b0;
            generate_next_sample <= 1'b0;
            beat                 <= 1'b0;
            strobe_cnt           <= '0;
        end else begin
            new_frame_d          <= new_frame;
            generate_next_sample <= frame_edge;
            beat                 <= 1'b0;
            // Beat lands together with the strobe that completes the count
            if (frame_edge) begin
                if (strobe_cnt == CNT_W'(BEAT_COUNT - 1)) begin
                    strobe_cnt <= '0;
                    beat       <= 1'b1;
                end else begin
                    strobe_cnt <= strobe_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/song_reader.sv */
/*
 * Song reader
 * Walks the song table and hands each note to the lowest-numbered idle voice
 */
`timescale 1ns/1ps

module song_reader (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         play,
    input  logic [music_pkg::SONG_W-1:0] song,
    input  logic                         note_done1,
    input  logic                         note_done2,
    input  logic                         note_done3,
    input  logic                         busy1,
    input  logic                         busy2,
    input  logic                         busy3,
    output logic [music_pkg::NOTE_W-1:0] note,
    output logic [music_pkg::NOTE_W-1:0] duration,
    output logic                         new_note1,
    output logic                         new_note2,
    output logic                         new_note3,
    output logic                         song_done
);

    logic [music_pkg::ENTRY_W-1:0] idx;
    logic                          entry_chord;
    logic [music_pkg::NOTE_W-1:0]  entry_note;
    logic [music_pkg::NOTE_W-1:0]  entry_dur;
    logic                          waiting;
    logic                          finished;
    logic [2:0]                    wait_mask;
    logic [2:0]                    idle;
    logic [2:0]                    pick;
    logic                          active;
    logic                          dispatch;
    logic                          end_hit;

    assign {entry_chord, entry_dur, entry_note} = music_pkg::song_entry(song, idx);

    // A voice with a new_note still in flight has not raised busy yet
    assign idle = ~{busy3, busy2, busy1} & ~{new_note3, new_note2, new_note1};
    // Lowest set bit
    assign pick = idle & (~idle + 3'd1);

    assign active   = play & ~waiting & ~finished;
    // Entry is held while every voice is taken
    assign dispatch = active & (entry_dur != '0) & (idle != 3'b000);
    // End only once the last voices have run out
    assign end_hit  = active & (entry_dur == '0) & (idle == 3'b111);

    always_ff @(posedge clk) begin
        if (reset) begin
            idx       <= '0;
            waiting   <= 1'b0;
            finished  <= 1'b0;
            wait_mask <= 3'b000;
            new_note1 <= 1'b0;
            new_note2 <= 1'b0;
            new_note3 <= 1'b0;
            song_done <= 1'b0;
        end else begin
            {new_note3, new_note2, new_note1} <= dispatch ? pick : 3'b000;
            song_done <= end_hit;
            if (end_hit) begin
                finished <= 1'b1;
            end
            if (dispatch) begin
                idx       <= idx + 1'b1;
                // Chord notes move straight on
                waiting   <= ~entry_chord;
                wait_mask <= pick;
            end else if (waiting && ((wait_mask & {note_done3, note_done2, note_done1}) != 3'b000)) begin
                waiting <= 1'b0;
            end
        end
    end

    // Shared note bus, only meaningful alongside a new_note pulse
    always_ff @(posedge clk) begin
        if (dispatch) begin
            note     <= entry_note;
            duration <= entry_dur;
        end
    end

endmodule

/* verilog/note_player.sv */
/*
 * Note player, one voice
 * Square wave from a phase accumulator, note length counted down in beats
 */
`timescale 1ns/1ps

module note_player (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  play_enable,
    input  logic                                  load_new_note,
    input  logic        [music_pkg::NOTE_W-1:0]   note_to_load,
    input  logic        [music_pkg::NOTE_W-1:0]   duration_to_load,
    input  logic                                  beat,
    input  logic                                  generate_next_sample,
    output logic                                  busy,
    output logic                                  done_with_note,
    output logic signed [music_pkg::SAMPLE_W-1:0] sample_out,
    output logic                                  new_sample_ready
);

    logic [music_pkg::NOTE_W-1:0]  note_q;
    logic [music_pkg::NOTE_W-1:0]  dur_left;
    logic [music_pkg::PHASE_W-1:0] phase;
    logic [music_pkg::PHASE_W-1:0] phase_next;
    logic                          advance;
    logic                          last_beat;
    logic                          sounding;

    // Pause freezes both phase and remaining duration
    assign advance    = generate_next_sample & busy & play_enable;
    assign phase_next = phase + music_pkg::note_step(note_q);
    assign last_beat  = advance & beat & (dur_left == 1);
    // Sample reflects the state after this frame's update
    assign sounding   = advance & ~last_beat & (note_q != '0);

    always_ff @(posedge clk) begin
        if (load_new_note) begin
            note_q   <= note_to_load;
            dur_left <= duration_to_load;
            phase    <= '0;
        end else if (advance) begin
            phase <= phase_next;
            if (beat) begin
                dur_left <= dur_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy             <= 1'b0;
            done_with_note   <= 1'b0;
            sample_out       <= '0;
            new_sample_ready <= 1'b0;
        end else begin
            done_with_note   <= last_beat;
            new_sample_ready <= generate_next_sample;
            if (load_new_note) begin
                busy <= 1'b1;
            end else if (last_beat) begin
                busy <= 1'b0;
            end
            if (generate_next_sample) begin
                if (!sounding) begin
                    sample_out <= '0;
                end else if (phase_next[music_pkg::PHASE_W-1]) begin
                    sample_out <= -music_pkg::VOICE_AMP;
                end else begin
                    sample_out <= music_pkg::VOICE_AMP;
                end
            end
        end
    end

endmodule

/* verilog/voice_mixer.sv */
/*
 * Voice mixer
 * Registered sum of three voices, each scaled to a quarter
 */
`timescale 1ns/1ps

module voice_mixer (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic signed [music_pkg::SAMPLE_W-1:0] sample1,
    input  logic signed [music_pkg::SAMPLE_W-1:0] sample2,
    input  logic signed [music_pkg::SAMPLE_W-1:0] sample3,
    input  logic                                  sample_ready,
    output logic signed [music_pkg::SAMPLE_W-1:0] mixed_sample,
    output logic                                  mixed_valid
);

    always_ff @(posedge clk) begin
        if (reset) begin
            mixed_valid <= 1'b0;
        end else begin
            mixed_valid <= sample_ready;
        end
    end

    // Three quarters of full scale at most, no overflow
    always_ff @(posedge clk) begin
        if (sample_ready) begin
            mixed_sample <= (sample1 >>> 2) + (sample2 >>> 2) + (sample3 >>> 2);
        end
    end

endmodule

/* verilog/codec_conditioner.sv */
/*
 * Codec conditioner
 * Holds the latest mix and releases it on the frame strobe
 */
`timescale 1ns/1ps

module codec_conditioner (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic signed [music_pkg::SAMPLE_W-1:0] new_sample_in,
    input  logic                                  latch_new_sample_in,
    input  logic                                  generate_next_sample,
    output logic signed [music_pkg::SAMPLE_W-1:0] valid_sample
);

    logic signed [music_pkg::SAMPLE_W-1:0] held;

    always_ff @(posedge clk) begin
        if (reset) begin
            held         <= '0;
            valid_sample <= '0;
        end else begin
            if (latch_new_sample_in) begin
                held <= new_sample_in;
            end
            // Codec sees one value for the whole frame
            if (generate_next_sample) begin
                valid_sample <= held;
            end
        end
    end

endmodule

/* verilog/music_player.sv */
/*
 * Music player top level
 * Control, frame timing, song reader, three voices, mixer and codec conditioner
 */
`timescale 1ns/1ps

module music_player #(
    parameter int BEAT_COUNT = 1000
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           play_button,
    input  logic                           next_button,
    input  logic                           new_frame,
    output logic                           new_sample_generated,
    output logic [music_pkg::SAMPLE_W-1:0] sample_out
);

    logic                                  play;
    logic                                  reset_player;
    logic [music_pkg::SONG_W-1:0]          song;
    logic                                  song_done;
    logic                                  player_reset;
    logic                                  generate_next_sample;
    logic                                  beat;
    logic [music_pkg::NOTE_W-1:0]          note;
    logic [music_pkg::NOTE_W-1:0]          duration;
    logic                                  new_note1;
    logic                                  new_note2;
    logic                                  new_note3;
    logic                                  note_done1;
    logic                                  note_done2;
    logic                                  note_done3;
    logic                                  busy1;
    logic                                  busy2;
    logic                                  busy3;
    logic signed [music_pkg::SAMPLE_W-1:0] voice_sample1;
    logic signed [music_pkg::SAMPLE_W-1:0] voice_sample2;
    logic signed [music_pkg::SAMPLE_W-1:0] voice_sample3;
    logic                                  sample_ready;
    logic signed [music_pkg::SAMPLE_W-1:0] mixed_sample;
    logic                                  mixed_valid;

    // A song change restarts the reader and silences leftover voices
    assign player_reset         = reset | reset_player;
    assign new_sample_generated = generate_next_sample;

    mcu u_mcu (.*);

    frame_sync #(.BEAT_COUNT(BEAT_COUNT)) u_frame_sync (.*);

    song_reader u_song_reader (
        .clk(clk), .reset(player_reset), .play(play), .song(song),
        .note_done1(note_done1), .note_done2(note_done2), .note_done3(note_done3),
        .busy1(busy1), .busy2(busy2), .busy3(busy3),
        .note(note), .duration(duration),
        .new_note1(new_note1), .new_note2(new_note2), .new_note3(new_note3),
        .song_done(song_done)
    );

    // Voices share the strobe, so voice 1's ready stands for all three
    note_player u_voice1 (
        .clk(clk), .reset(player_reset), .play_enable(play),
        .load_new_note(new_note1), .note_to_load(note), .duration_to_load(duration),
        .beat(beat), .generate_next_sample(generate_next_sample),
        .busy(busy1), .done_with_note(note_done1),
        .sample_out(voice_sample1), .new_sample_ready(sample_ready)
    );

    note_player u_voice2 (
        .clk(clk), .reset(player_reset), .play_enable(play),
        .load_new_note(new_note2), .note_to_load(note), .duration_to_load(duration),
        .beat(beat), .generate_next_sample(generate_next_sample),
        .busy(busy2), .done_with_note(note_done2),
        .sample_out(voice_sample2), .new_sample_ready()
    );

    note_player u_voice3 (
        .clk(clk), .reset(player_reset), .play_enable(play),
        .load_new_note(new_note3), .note_to_load(note), .duration_to_load(duration),
        .beat(beat), .generate_next_sample(generate_next_sample),
        .busy(busy3), .done_with_note(note_done3),
        .sample_out(voice_sample3), .new_sample_ready()
    );

    voice_mixer u_voice_mixer (
        .clk(clk), .reset(reset),
        .sample1(voice_sample1), .sample2(voice_sample2), .sample3(voice_sample3),
        .sample_ready(sample_ready),
        .mixed_sample(mixed_sample), .mixed_valid(mixed_valid)
    );

    codec_conditioner u_codec_conditioner (
        .clk(clk), .reset(reset),
        .new_sample_in(mixed_sample), .latch_new_sample_in(mixed_valid),
        .generate_next_sample(generate_next_sample),
        .valid_sample(sample_out)
    );

endmodule

/* test/clock_gen.sv */
/*
 * Testbench clock and reset source
 * Free-running clock and a reset held for a fixed number of cycles
 */
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release just after an edge so the DUT sees a clean deassertion
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* test/music_player_checker.sv */
/*
 * Music player checker
 * Frame-level reference model of control, reader and voices, compared per strobe
 */
`timescale 1ns/1ps

module music_player_checker #(
    parameter int BEAT_COUNT = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           play_button,
    input  logic                           next_button,
    input  logic                           new_frame,
    input  logic                           new_sample_generated,
    input  logic [music_pkg::SAMPLE_W-1:0] sample_out,
    input  logic                           dut_play,
    input  logic [music_pkg::SONG_W-1:0]   dut_song,
    input  int                             test_id,
    input  logic                           tests_done,
    output int                             error_count,
    output int                             check_count
);

    localparam int NW = music_pkg::NOTE_W;

    // Model state
    int strobe_n;
    bit m_play;
    int m_song;
    bit v_busy [3];
    int v_note [3];
    int v_dur [3];
    int v_phase [3];
    int r_idx;
    bit r_wait;
    int r_wait_v;

    int last_mix;
    int expect_mix;
    bit check_due;
    bit frame_d;
    int edges;
    int strobes;
    int cur_test;
    int test_checks;
    int test_errors;
    bit final_done;

    function automatic string test_name(input int id);
        case (id)
            1: return "idle after reset";
            2: return "one strobe per frame";
            3: return "song 0 to its end";
            4: return "pause and resume";
            5: return "song stepping";
            default: return "unknown";
        endcase
    endfunction

    // Song change, from next_button or song end
    function automatic void restart_player();
        m_play = 1'b0;
        m_song = (m_song + 1) % music_pkg::SONG_COUNT;
        for (int i = 0; i < 3; i++) v_busy[i] = 1'b0;
        r_idx  = 0;
        r_wait = 1'b0;
    endfunction

    // Everything the reader does between two strobes
    function automatic void dispatch_notes();
        logic [2*NW:0] e;
        int            dur;
        int            free_v;
        bit            more;
        more = m_play && !r_wait;
        while (more) begin
            more   = 1'b0;
            e      = music_pkg::song_entry(m_song[1:0], r_idx[3:0]);
            dur    = int'(e[2*NW-1:NW]);
            free_v = -1;
            for (int i = 2; i >= 0; i--) begin
                if (!v_busy[i]) free_v = i;
            end
            if (dur == 0) begin
                // End entry waits until every voice has run out
                if (!v_busy[0] && !v_busy[1] && !v_busy[2]) restart_player();
            end else if (free_v >= 0) begin
                v_busy[free_v]  = 1'b1;
                v_note[free_v]  = int'(e[NW-1:0]);
                v_dur[free_v]   = dur;
                v_phase[free_v] = 0;
                r_idx           = r_idx + 1;
                r_wait          = !e[2*NW];
                r_wait_v        = free_v;
                more            = !r_wait;
            end
        end
    endfunction

    // Reference model, one frame: beat, voices, dispatch, mix
    function automatic int advance_frame();
        bit beat;
        int mix;
        int smp;
        int step;
        strobe_n++;
        beat = (strobe_n % BEAT_COUNT) == 0;
        mix  = 0;
        for (int i = 0; i < 3; i++) begin
            smp = 0;
            if (v_busy[i] && m_play) begin
                step       = int'(music_pkg::note_step(v_note[i][NW-1:0]));
                v_phase[i] = (v_phase[i] + step) % 65536;
                if (beat) v_dur[i]--;
                if (v_dur[i] == 0) begin
                    v_busy[i] = 1'b0;
                    if (r_wait && r_wait_v == i) r_wait = 1'b0;
                end else if (v_note[i] != 0) begin
                    smp = (v_phase[i] >= 32768) ? -int'(music_pkg::VOICE_AMP)
                                                : int'(music_pkg::VOICE_AMP);
                end
            end
            mix += smp >>> 2;
        end
        dispatch_notes();
        return mix;
    endfunction

    task automatic report_test(input int id);
        $display("Test %0d (%s): %0d checks, %0d errors", id, test_name(id),
                 test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic count_check(input bit ok);
        check_count++;
        test_checks++;
        if (!ok) begin
            error_count++;
            test_errors++;
        end
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        cur_test    = 0;
        test_checks = 0;
        test_errors = 0;
        final_done  = 1'b0;
    end

    // Inputs change 1 ns after the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (reset) begin
            strobe_n  = 0;
            m_play    = 1'b0;
            m_song    = 0;
            for (int i = 0; i < 3; i++) begin
                v_busy[i]  = 1'b0;
                v_phase[i] = 0;
            end
            r_idx     = 0;
            r_wait    = 1'b0;
            last_mix  = 0;
            check_due = 1'b0;
            frame_d   = 1'b0;
            edges     = 0;
            strobes   = 0;
        end else begin
            if (test_id != cur_test) begin
                if (cur_test != 0) report_test(cur_test);
                cur_test = test_id;
            end
            if (check_due) begin
                check_due = 1'b0;
                count_check(int'($signed(sample_out)) == expect_mix);
                if (int'($signed(sample_out)) != expect_mix) begin
                    $display("[ERROR] %0t ns: sample_out expected %0d, got %0d",
                             $time, expect_mix, $signed(sample_out));
                end
            end
            if (new_frame && !frame_d) edges++;
            frame_d = new_frame;
            if (new_sample_generated) begin
                strobes++;
                count_check(dut_play == m_play && int'(dut_song) == m_song);
                if (dut_play != m_play || int'(dut_song) != m_song) begin
                    $display("[ERROR] %0t ns: play/song expected %0d/%0d, got %0d/%0d",
                             $time, m_play, m_song, dut_play, dut_song);
                end
                // Output of this frame is the mix of the previous one
                expect_mix = last_mix;
                last_mix   = advance_frame();
                check_due  = 1'b1;
            end
            if (next_button) begin
                restart_player();
            end else if (play_button) begin
                m_play = !m_play;
                dispatch_notes();
            end
            if (tests_done && !final_done) begin
                final_done = 1'b1;
                report_test(cur_test);
                count_check(edges == strobes && edges > 0);
                if (edges != strobes || edges == 0) begin
                    $display("[ERROR] %0t ns: %0d frame edges but %0d sample strobes",
                             $time, edges, strobes);
                end
                report_test(2);
            end
        end
    end

endmodule

/* test/music_player_assert.sv */
/*
 * Music player protocol assertions
 * Strobe spacing, voice busy start and output update timing
 */
`timescale 1ns/1ps

module music_player_assert (
    input logic                           clk,
    input logic                           reset,
    input logic                           new_sample_generated,
    input logic [music_pkg::SAMPLE_W-1:0] sample_out,
    input logic                           busy1,
    input logic                           busy2,
    input logic                           busy3,
    input logic                           new_note1,
    input logic                           new_note2,
    input logic                           new_note3
);

    strobe_single: assert property (@(posedge clk) disable iff (reset)
        new_sample_generated |=> !new_sample_generated)
        else $error("sample strobe high two cycles in a row");

    // A voice only starts on its own load pulse
    busy1_start: assert property (@(posedge clk) disable iff (reset)
        $rose(busy1) |-> $past(new_note1))
        else $error("voice 1 went busy without new_note");
    busy2_start: assert property (@(posedge clk) disable iff (reset)
        $rose(busy2) |-> $past(new_note2))
        else $error("voice 2 went busy without new_note");
    busy3_start: assert property (@(posedge clk) disable iff (reset)
        $rose(busy3) |-> $past(new_note3))
        else $error("voice 3 went busy without new_note");

    sample_timing: assert property (@(posedge clk) disable iff (reset)
        (sample_out != $past(sample_out)) |-> $past(new_sample_generated))
        else $error("sample_out changed outside the cycle after a strobe");

endmodule

bind music_player music_player_assert u_music_player_assert (
    .clk(clk), .reset(reset), .new_sample_generated(new_sample_generated),
    .sample_out(sample_out), .busy1(busy1), .busy2(busy2), .busy3(busy3),
    .new_note1(new_note1), .new_note2(new_note2), .new_note3(new_note3)
);

/* test/music_player_tb.sv */
/*
 * Music player testbench top
 * Frame generator, button stimulus, UUT, checker and run timeout
 */
`timescale 1ns/1ps

module music_player_tb;

    localparam int BEAT_COUNT     = 4;
    // Frame budget per test: idle, song 0, pause test, song stepping, tail
    localparam int TOTAL_FRAMES   = 6 + 63 + 50 + 4 * 12 + 8;
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * 20 + 200;

    logic                           clk;
    logic                           reset;
    logic                           play_button;
    logic                           next_button;
    logic                           new_frame;
    logic                           new_sample_generated;
    logic [music_pkg::SAMPLE_W-1:0] sample_out;
    int                             frame_cyc;
    int                             test_id;
    logic                           tests_done;
    int                             error_count;
    int                             check_count;
    int                             tb_errors;
    int                             cycles;
    int                             seed;

    clock_gen #(.PERIOD(8), .RESET_CYCLES(5)) u_clock_gen (.clk(clk), .reset(reset));

    music_player #(.BEAT_COUNT(BEAT_COUNT)) UUT (
        .clk(clk), .reset(reset), .play_button(play_button), .next_button(next_button),
        .new_frame(new_frame), .new_sample_generated(new_sample_generated),
        .sample_out(sample_out)
    );

    music_player_checker #(.BEAT_COUNT(BEAT_COUNT)) u_checker (
        .clk(clk), .reset(reset), .play_button(play_button), .next_button(next_button),
        .new_frame(new_frame), .new_sample_generated(new_sample_generated),
        .sample_out(sample_out), .dut_play(UUT.play), .dut_song(UUT.song),
        .test_id(test_id), .tests_done(tests_done),
        .error_count(error_count), .check_count(check_count)
    );

    // Codec frame level, high 2 cycles out of 20
    initial begin
        new_frame = 1'b0;
        frame_cyc = 0;
        @(negedge reset);
        forever begin
            @(posedge clk);
            #1;
            new_frame = (frame_cyc < 2);
            frame_cyc = (frame_cyc == 19) ? 0 : frame_cyc + 1;
        end
    end

    // Lands mid-frame, well clear of the strobe and note dispatch
    task automatic wait_frames(input int n);
        repeat (n) begin
            do @(posedge clk); while (frame_cyc != 10);
        end
    endtask

    task automatic press_button(input bit is_next);
        #1;
        if (is_next) next_button = 1'b1;
        else play_button = 1'b1;
        @(posedge clk);
        #1;
        play_button = 1'b0;
        next_button = 1'b0;
    endtask

    task automatic wait_song_end(input int max_frames);
        int n;
        n = 0;
        do begin
            wait_frames(1);
            n++;
        end while (UUT.play && n < max_frames);
        if (UUT.play) begin
            $display("Song still playing after %0d frames", max_frames);
            tb_errors++;
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        play_button = 1'b0;
        next_button = 1'b0;
        test_id     = 0;
        tests_done  = 1'b0;
        tb_errors   = 0;
        cycles      = 0;
        seed        = 37642;
        @(negedge reset);

        // Idle, strobes run but nothing sounds
        test_id = 1;
        wait_frames(6);

        // Song 0 start to finish
        test_id = 3;
        wait_frames(1 + ($random(seed) & 3));
        press_button(1'b0);
        wait_song_end(50);
        wait_frames(2);

        // Pause in the middle of the first note of song 1
        test_id = 4;
        wait_frames(1 + ($random(seed) & 1));
        press_button(1'b0);
        wait_frames(3 + ($random(seed) & 1));
        press_button(1'b0);
        wait_frames(3);
        press_button(1'b0);
        wait_song_end(40);

        // Step through songs, each one interrupted by the next press
        test_id = 5;
        repeat (4) begin
            wait_frames(1 + ($random(seed) & 1));
            press_button(1'b1);
            wait_frames(1);
            press_button(1'b0);
            wait_frames(3 + ($random(seed) & 3));
        end
        press_button(1'b1);
        wait_frames(2);

        tests_done = 1'b1;
        repeat (3) @(posedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count + tb_errors);
        if (error_count + tb_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
verilog/music_pkg.sv
verilog/mcu.sv
verilog/frame_sync.sv
verilog/song_reader.sv
verilog/note_player.sv
verilog/voice_mixer.sv
verilog/codec_conditioner.sv
verilog/music_player.sv
test/clock_gen.sv
test/music_player_checker.sv
test/music_player_assert.sv
test/music_player_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the music player testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module music_player_tb -f vlog.f -o sim_music_player
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output="$(./obj_dir/sim_music_player)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
